// ==== build.f ====
+incdir+src
src/io_map_pkg.sv
src/io_regs_pkg.sv
src/io_decode.sv
src/clock_div_regs.sv
src/sysinfo_regs.sv
src/mtime_prescaler.sv
src/io_responder.sv
src/io_fabric.sv
verif/tb_io_fabric.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_io_fabric
FILELIST  = build.f
BUILD_DIR = obj_dir
PASS_MSG  = Simulation passed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/io_fabric_testdata.txt ====
# B addr wstrb wdata instr exp_rdata exp_fault exp_reboot  (bus op, hex, rdata checked on reads)
# T steps exp_mtime  (timer step, steps in decimal, mtime in hex)
B 1000000C 0 00000000 0 00000001 0 0
B 10000010 0 00000000 0 00000001 0 0
B 1000000C F A5A51234 0 00000000 0 0
B 1000000C 0 00000000 0 A5A51234 0 0
B 10000010 F DEAD0001 0 00000000 0 0
B 10000010 0 00000000 0 DEAD0001 0 0
B 10000014 0 00000000 0 00003200 0 0
B 10000014 F 00000040 0 00000000 0 0
B 10000014 0 00000000 0 00000100 0 0
B 10000014 F 00003200 0 00000000 0 0
B 10000014 0 00000000 0 00003200 0 0
B 10000018 0 00000000 0 02000000 0 0
B 10000018 F 12345678 0 00000000 0 0
B 10000018 0 00000000 0 02000000 0 0
B 10000020 0 00000000 0 00000000 0 0
B 02000000 0 00000000 0 00000000 0 0
B 80000000 0 00000000 0 00000000 1 0
B 80000000 F 11111111 0 00000000 1 0
B 10000000 0 00000000 1 00000000 1 0
B 11100000 F 00007777 0 00000000 0 1
B 11100000 F 00001234 0 00000000 0 0
T 3 0000000000000003
T 2 0000000000000005
B 10000010 F 00000004 0 00000000 0 0
T 1 0000000000000000
T 3 0000000000000000
T 1 0000000000000001
T 4 0000000000000002
T 8 0000000000000004

// ==== verif/tb_io_fabric.sv ====
// replays the bus operations and timer steps of the testdata file against io_fabric
`include "io_settings.svh"

module tb_io_fabric;

  timeunit 1ns;
  timeprecision 100ps;

  import io_map_pkg::*;
  import io_regs_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int CYCLES_PER_LINE = 40;
  localparam int READY_WAIT = 8; // give up on a request after this many cycles

  // one parsed line of the testdata file
  typedef struct packed {
    logic        is_timer;
    logic [31:0] addr;
    logic [3:0]  wstrb;
    logic [31:0] wdata;
    logic        instr;
    logic [31:0] exp_rdata;
    logic        exp_fault;
    logic        exp_reboot;
    logic [15:0] steps;
    logic [63:0] exp_mtime;
  } test_line_t;

  logic        clk;
  logic        resetn;
  bus_req_t    bus_req;
  logic [63:0] timer_counter;
  bus_rsp_t    bus_rsp;
  logic        access_fault;
  logic        reboot;
  div_cfg_t    div_cfg;
  q8_8_t       sysclk_mhz;
  logic [63:0] mtime;

  test_line_t  lines[$];
  int          value_errs;
  int          other_errs;
  int          cycle_limit;
  int          cycle_cnt;

  io_fabric io_fabric_inst (
    .clk               (clk),
    .resetn            (resetn),
    .bus_req_i         (bus_req),
    .timer_counter_i   (timer_counter),
    .bus_rsp_o         (bus_rsp),
    .access_fault_o    (access_fault),
    .reboot_o          (reboot),
    .div_cfg_o         (div_cfg),
    .sysclk_mhz_q8_8_o (sysclk_mhz),
    .mtime_o           (mtime)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      value_errs++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          n;
    string       text;
    test_line_t  t;
    logic [31:0] f_addr;
    logic [31:0] f_strb;
    logic [31:0] f_data;
    logic [31:0] f_instr;
    logic [31:0] f_rdata;
    logic [31:0] f_fault;
    logic [31:0] f_reboot;
    logic [31:0] f_steps;
    logic [63:0] f_mtime;
    fd = $fopen("verif/io_fabric_testdata.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("could not open the testdata file");
      return;
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      t = '0;
      if (n > 0 && text.len() > 0 && text[0] == "B") begin
        n = $sscanf(text, "B %h %h %h %h %h %h %h", f_addr, f_strb, f_data, f_instr,
                    f_rdata, f_fault, f_reboot);
        if (n == 7) begin
          t.addr = f_addr;
          t.wstrb = f_strb[3:0];
          t.wdata = f_data;
          t.instr = f_instr[0];
          t.exp_rdata = f_rdata;
          t.exp_fault = f_fault[0];
          t.exp_reboot = f_reboot[0];
          lines.push_back(t);
        end else begin
          other_errs++;
          $display("bus line in testdata has %0d fields instead of 7", n);
        end
      end else if (n > 0 && text.len() > 0 && text[0] == "T") begin
        n = $sscanf(text, "T %d %h", f_steps, f_mtime);
        if (n == 2) begin
          t.is_timer = 1'b1;
          t.steps = f_steps[15:0];
          t.exp_mtime = f_mtime;
          lines.push_back(t);
        end else begin
          other_errs++;
          $display("timer line in testdata has %0d fields instead of 2", n);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_bus_op(input test_line_t t);
    int   cycles;
    logic seen;
    logic data_wr;
    @(posedge clk);
    #2;
    bus_req.valid = 1'b1;
    bus_req.addr = t.addr;
    bus_req.wstrb = t.wstrb;
    bus_req.wdata = t.wdata;
    bus_req.is_instruction = t.instr;
    data_wr = (t.wstrb != 4'h0) && !t.instr;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < READY_WAIT) begin
      @(posedge clk);
      #1;
      cycles++;
      if (bus_rsp.ready)
        seen = 1'b1;
    end
    assert (seen) else begin
      other_errs++;
      $display("request to %h got no ready within %0d cycles", t.addr, READY_WAIT);
    end
    if (seen) begin
      assert (cycles == 1) else begin
        other_errs++;
        $display("ready for %h came %0d cycles after valid instead of one", t.addr, cycles);
      end
      if (t.wstrb == 4'h0)
        check_value("bus_rsp_o.rdata", 64'(bus_rsp.rdata), 64'(t.exp_rdata)); // reads only
      check_value("access_fault_o", 64'(access_fault), 64'(t.exp_fault));
      check_value("reboot_o", 64'(reboot), 64'(t.exp_reboot));
      if (data_wr && t.addr == `DIV_ADDR0)
        check_value("div_cfg_o.div0", 64'(div_cfg.div0), 64'(t.wdata));
      if (data_wr && t.addr == `DIV_ADDR1)
        check_value("div_cfg_o.div1", 64'(div_cfg.div1), 64'(t.wdata));
      // the frequency output carries the value a read returns
      if (t.wstrb == 4'h0 && !t.instr && t.addr == `CPU_FREQ_ADDR)
        check_value("sysclk_mhz_q8_8_o", 64'(sysclk_mhz), 64'(t.exp_rdata[15:0]));
    end
    #1;
    bus_req = '0; // drop valid before the next edge
  endtask

  // each counter change is held for two cycles
  task automatic run_timer_step(input test_line_t t);
    repeat (t.steps) begin
      @(posedge clk);
      #2;
      timer_counter = timer_counter + 64'd1;
      @(posedge clk);
    end
    #1;
    check_value("mtime_o", mtime, t.exp_mtime);
  endtask

  initial begin
    wait (cycle_limit > 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, run stopped after %0d cycles", cycle_cnt);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    bus_req = '0;
    timer_counter = 64'd0;
    resetn = 1'b0;
    value_errs = 0;
    other_errs = 0;
    cycle_cnt = 0;
    cycle_limit = 0;
    load_testdata();
    cycle_limit = CYCLES_PER_LINE * lines.size() + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    // outputs while reset is still applied
    check_value("bus_rsp_o.ready", 64'(bus_rsp.ready), 64'd0);
    check_value("access_fault_o", 64'(access_fault), 64'd0);
    check_value("reboot_o", 64'(reboot), 64'd0);
    #1;
    resetn = 1'b1;
    foreach (lines[i]) begin
      if (lines[i].is_timer)
        run_timer_step(lines[i]);
      else
        run_bus_op(lines[i]);
    end
    @(posedge clk);
    $display("%0d lines run, %0d value errors, %0d other errors", lines.size(), value_errs,
             other_errs);
    if (value_errs == 0 && other_errs == 0 && lines.size() > 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== src/io_fabric.sv ====
// top of the SoC I/O side, decodes the processor request and returns one reply per access
module io_fabric (
  input  logic                  clk,
  input  logic                  resetn,
  input  io_map_pkg::bus_req_t  bus_req_i,
  input  logic [63:0]           timer_counter_i,
  output io_regs_pkg::bus_rsp_t bus_rsp_o,
  output logic                  access_fault_o,
  output logic                  reboot_o,
  output io_regs_pkg::div_cfg_t div_cfg_o,
  output io_regs_pkg::q8_8_t    sysclk_mhz_q8_8_o,
  output logic [63:0]           mtime_o
);

  import io_map_pkg::*;
  import io_regs_pkg::*;

  io_sel_t  sel;
  bus_rsp_t div_rsp;
  bus_rsp_t sys_rsp;
  div_cfg_t div_cfg;

  io_decode io_decode_inst (
    .req_i (bus_req_i),
    .sel_o (sel)
  );

  clock_div_regs clock_div_regs_inst (
    .clk       (clk),
    .resetn    (resetn),
    .req_i     (bus_req_i),
    .sel_i     (sel),
    .rsp_o     (div_rsp),
    .div_cfg_o (div_cfg)
  );

  sysinfo_regs sysinfo_regs_inst (
    .clk    (clk),
    .resetn (resetn),
    .req_i  (bus_req_i),
    .sel_i  (sel),
    .rsp_o  (sys_rsp),
    .freq_o (sysclk_mhz_q8_8_o)
  );

  mtime_prescaler mtime_prescaler_inst (
    .clk             (clk),
    .resetn          (resetn),
    .timer_counter_i (timer_counter_i),
    .div_cfg_i       (div_cfg),
    .mtime_o         (mtime_o)
  );

  io_responder io_responder_inst (
    .clk            (clk),
    .resetn         (resetn),
    .req_i          (bus_req_i),
    .sel_i          (sel),
    .div_rsp_i      (div_rsp),
    .sys_rsp_i      (sys_rsp),
    .rsp_o          (bus_rsp_o),
    .access_fault_o (access_fault_o),
    .reboot_o       (reboot_o)
  );

  assign div_cfg_o = div_cfg; // uart and spi dividers for outside peripherals

endmodule

// ==== src/io_responder.sv ====
// registered replies for unmatched, faulting and reboot accesses, and the merge of all I/O replies
module io_responder (
  input  logic                  clk,
  input  logic                  resetn,
  input  io_map_pkg::bus_req_t  req_i,
  input  io_map_pkg::io_sel_t   sel_i,
  input  io_regs_pkg::bus_rsp_t div_rsp_i,
  input  io_regs_pkg::bus_rsp_t sys_rsp_i,
  output io_regs_pkg::bus_rsp_t rsp_o,
  output logic                  access_fault_o,
  output logic                  reboot_o
);

  import io_regs_pkg::*;

  logic     unmatched_q;
  logic     fault_q;
  logic     reboot_q;
  bus_rsp_t merged;

  // each flag pulses once per held request
  always_ff @(posedge clk) begin
    if (!resetn) begin
      unmatched_q <= 1'b0;
      fault_q <= 1'b0;
      reboot_q <= 1'b0;
    end else begin
      unmatched_q <= sel_i.unmatched && !unmatched_q;
      fault_q <= sel_i.fault && !fault_q;
      reboot_q <= sel_i.reboot_hit && !reboot_q;
    end
  end

  always_comb begin
    merged = '0;
    if (sys_rsp_i.ready) begin
      merged = sys_rsp_i;
    end else if (div_rsp_i.ready) begin
      merged = div_rsp_i;
    end else if (unmatched_q) begin
      merged.ready = 1'b1; // reads as zero
    end else if (fault_q) begin
      merged.ready = 1'b1;
    end else if (reboot_q) begin
      merged.ready = 1'b1; // the reboot write still needs its ack
    end
  end

  // replies only go out while the master still holds the request
  assign rsp_o = req_i.valid ? merged : '0;
  assign access_fault_o = fault_q;
  assign reboot_o = reboot_q;

  // decode keeps the classes disjoint, so no reply is ever hidden by the priority
  a_one_source : assert property (
    @(posedge clk) disable iff (!resetn)
      $onehot0({sys_rsp_i.ready, div_rsp_i.ready, unmatched_q, fault_q, reboot_q})
  );

endmodule

// ==== src/mtime_prescaler.sv ====
// machine-timer prescaler, divides the microsecond counter by the low half of divider word 1
module mtime_prescaler (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [63:0]           timer_counter_i,
  input  io_regs_pkg::div_cfg_t div_cfg_i,
  output logic [63:0]           mtime_o
);

  logic [63:0] prev_cnt_q; // last counter value seen
  logic [15:0] presc_q;
  logic [15:0] div_lat_q;  // divisor latched at the last reload
  logic [63:0] count_q;
  logic [15:0] div_safe;
  logic        tick;
  logic        bypass;

  assign tick = (timer_counter_i != prev_cnt_q);
  assign div_safe = (div_cfg_i.div1[15:0] == 16'd0) ? 16'd1 : div_cfg_i.div1[15:0];
  assign bypass = (div_lat_q == 16'd1);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      prev_cnt_q <= 64'd0;
      presc_q <= 16'd0;
      div_lat_q <= 16'd1;
      count_q <= 64'd0;
    end else if (tick) begin
      prev_cnt_q <= timer_counter_i;
      if (bypass) begin
        // pick up a new divisor on the next change
        presc_q <= 16'd0;
        div_lat_q <= div_safe;
      end else if (presc_q == div_lat_q - 16'd1) begin
        presc_q <= 16'd0;
        count_q <= count_q + 64'd1;
        div_lat_q <= div_safe; // divisor changes take effect at a period boundary
      end else begin
        presc_q <= presc_q + 16'd1;
      end
    end
  end

  // divide by one passes the counter straight through
  assign mtime_o = bypass ? timer_counter_i : count_q;

endmodule

// ==== src/sysinfo_regs.sv ====
// system-information registers: writable CPU frequency in Q8.8 MHz and the read-only memory size
`include "io_settings.svh"

module sysinfo_regs (
  input  logic                  clk,
  input  logic                  resetn,
  input  io_map_pkg::bus_req_t  req_i,
  input  io_map_pkg::io_sel_t   sel_i,
  output io_regs_pkg::bus_rsp_t rsp_o,
  output io_regs_pkg::q8_8_t    freq_o
);

  import io_regs_pkg::*;

  // SYSTEM_CLK in MHz, fraction rounded to the nearest 1/256
  localparam int unsigned MHZ_INT = `SYSTEM_CLK / 1_000_000;
  localparam int unsigned MHZ_FRAC = (((`SYSTEM_CLK % 1_000_000) * 256) + 500_000) / 1_000_000;
  localparam int unsigned RESET_RAW = (MHZ_INT << 8) + MHZ_FRAC;
  localparam q8_8_t FREQ_RESET = (RESET_RAW > 32'h0000_FFFF) ? 16'hFFFF : RESET_RAW[15:0];

  q8_8_t       freq_q;
  q8_8_t       freq_wr;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        accept;
  logic        wr;

  assign wr = |req_i.wstrb;
  assign accept = (sel_i.freq || sel_i.memsize) && !ready_q;

  // values below 1 MHz would break software delay loops
  assign freq_wr = (req_i.wdata[15:0] < `FREQ_MIN_Q8_8) ? `FREQ_MIN_Q8_8 : req_i.wdata[15:0];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      freq_q <= FREQ_RESET;
    end else begin
      ready_q <= accept;
      if (accept && wr && sel_i.freq)
        freq_q <= freq_wr; // memsize writes just get acked
    end
  end

  always_ff @(posedge clk) begin
    if (accept)
      rdata_q <= sel_i.freq ? {16'h0000, freq_q} : `SDRAM_SIZE;
  end

  assign rsp_o = '{ready: ready_q, rdata: (ready_q ? rdata_q : 32'h0)};
  assign freq_o = freq_q;

endmodule

// ==== src/clock_div_regs.sv ====
// two 32-bit clock-divider registers on the I/O bus, values exported for outside peripherals
`include "io_settings.svh"

module clock_div_regs (
  input  logic                 clk,
  input  logic                 resetn,
  input  io_map_pkg::bus_req_t req_i,
  input  io_map_pkg::io_sel_t  sel_i,
  output io_regs_pkg::bus_rsp_t rsp_o,
  output io_regs_pkg::div_cfg_t div_cfg_o
);

  import io_regs_pkg::*;

  div_cfg_t    div_q;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        accept;
  logic        wr;

  assign wr = |req_i.wstrb;
  assign accept = (sel_i.div0 || sel_i.div1) && !ready_q; // one reply per held request

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
      div_q.div0 <= `DIV_RESET;
      div_q.div1 <= `DIV_RESET;
    end else begin
      ready_q <= accept;
      if (accept && wr && sel_i.div0)
        div_q.div0 <= req_i.wdata;
      if (accept && wr && sel_i.div1)
        div_q.div1 <= req_i.wdata;
    end
  end

  // read data captured before the write lands
  always_ff @(posedge clk) begin
    if (accept)
      rdata_q <= sel_i.div0 ? div_q.div0 : div_q.div1;
  end

  assign rsp_o = '{ready: ready_q, rdata: (ready_q ? rdata_q : 32'h0)};
  assign div_cfg_o = div_q;

  // the master drops valid after the pulse, so no request is served twice
  a_single_ready : assert property (
    @(posedge clk) disable iff (!resetn) ready_q |=> !ready_q
  );

endmodule

// ==== src/io_decode.sv ====
// combinational address decode of the processor request into one select bit per I/O target
`include "io_settings.svh"

module io_decode (
  input  io_map_pkg::bus_req_t req_i,
  output io_map_pkg::io_sel_t  sel_o
);

  logic wr;
  logic data_acc;
  logic in_window;
  logic in_tagged;
  logic in_io;
  logic reboot_hit;
  logic reg_hit;
  logic fault;

  assign wr = |req_i.wstrb;
  assign data_acc = req_i.valid && !req_i.is_instruction; // registers only see data accesses

  assign in_window = (req_i.addr >= `IO_LO) && (req_i.addr <= `IO_HI);
  assign in_tagged = (req_i.addr[31:24] == `CLINT_TAG) || (req_i.addr[31:24] == `PLIC_TAG);
  assign in_io = req_i.valid && (in_window || in_tagged);

  assign reboot_hit = data_acc && wr && (req_i.addr == `REBOOT_ADDR) &&
                      (req_i.wdata[15:0] == `REBOOT_DATA);

  assign sel_o.div0 = data_acc && (req_i.addr == `DIV_ADDR0);
  assign sel_o.div1 = data_acc && (req_i.addr == `DIV_ADDR1);
  assign sel_o.freq = data_acc && (req_i.addr == `CPU_FREQ_ADDR);
  assign sel_o.memsize = data_acc && (req_i.addr == `MEM_SIZE_ADDR);
  assign sel_o.reboot_hit = reboot_hit;
  assign sel_o.in_io = in_io;

  assign reg_hit = sel_o.div0 || sel_o.div1 || sel_o.freq || sel_o.memsize || reboot_hit;

  // no instruction memory is kept here, so every fetch faults
  always_comb begin
    fault = 1'b0;
    if (`ENABLE_ACCESS_FAULT == 1'b1) begin
      if (req_i.valid && req_i.is_instruction)
        fault = 1'b1;
      else if (data_acc && !in_io && !reboot_hit)
        fault = 1'b1;
    end
  end

  assign sel_o.fault = fault;

  // fault takes the reply, otherwise two sources would answer one fetch
  assign sel_o.unmatched = in_io && !reg_hit && !fault;

endmodule

// ==== src/io_regs_pkg.sv ====
// register-content and reply types of the I/O fabric, imported by the register blocks and top
package io_regs_pkg;

  // both clock-divider words
  typedef struct packed {
    logic [31:0] div0;
    logic [31:0] div1; // low half is the machine-timer divisor
  } div_cfg_t;

  // unsigned frequency in MHz, 8 integer and 8 fraction bits
  typedef logic [15:0] q8_8_t;

  // one reply on the bus, rdata zero while ready is low
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bus_rsp_t;

endpackage

// ==== src/io_map_pkg.sv ====
// bus request and address-selection types, imported by the decode and the reply blocks
package io_map_pkg;

  // request as the processor presents it, held stable until ready
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [3:0]  wstrb;          // all zero means read
    logic [31:0] wdata;
    logic        is_instruction; // fetch, not a data access
  } bus_req_t;

  // one bit per target, already qualified by valid
  typedef struct packed {
    logic div0;
    logic div1;
    logic freq;
    logic memsize;
    logic reboot_hit; // write of the reboot magic to the reboot address
    logic in_io;      // I/O window or the CLINT/PLIC tagged windows
    logic unmatched;  // in_io with no register behind it
    logic fault;      // access-fault reply wanted
  } io_sel_t;

endpackage

// ==== src/io_settings.svh ====
// address map, reset values and build options shared by the I/O fabric RTL, include where needed
`ifndef IO_SETTINGS_SVH
`define IO_SETTINGS_SVH

// register addresses inside the I/O window
`define DIV_ADDR0 32'h1000_000C
`define DIV_ADDR1 32'h1000_0010
`define CPU_FREQ_ADDR 32'h1000_0014
`define MEM_SIZE_ADDR 32'h1000_0018
`define REBOOT_ADDR 32'h1110_0000

// I/O window, bounds inclusive
`define IO_LO 32'h1000_0000
`define IO_HI 32'h1200_0000

// high-byte tags of the CLINT and PLIC windows
`define CLINT_TAG 8'h02
`define PLIC_TAG 8'h0C

// magic value in the low half of a reboot write
`define REBOOT_DATA 16'h7777

// system clock in Hz
`define SYSTEM_CLK 50_000_000

// external memory size reported to software, in bytes
`define SDRAM_SIZE 32'h0200_0000

`define DIV_RESET 32'd1

// lowest allowed frequency, 1.0 MHz in Q8.8
`define FREQ_MIN_Q8_8 16'h0100

// set to 0 to leave accesses outside the map without a reply
`define ENABLE_ACCESS_FAULT 1'b1

`endif
